// File: design/addr_gen.sv
// Address channel generator
`default_nettype none
`include "mst_macros.svh"

module addr_gen
    import mst_pkg::*;
(
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         en,
    input  addr_t                        addr_min,
    input  addr_t                        addr_max,
    input  logic                         slot_busy,
    input  logic                         hold,
    output logic                         valid,
    input  logic                         ready,
    output addr_req_t                    req,
    output logic [$clog2(`MST_OSTD)-1:0] slot,
    output logic                         stall_err
);

    localparam int SW = $clog2(`MST_OSTD);
    localparam int TW = $clog2(`MST_TIMEOUT + 1);
    localparam logic [TW-1:0] TMO = TW'(`MST_TIMEOUT);

    logic [31:0]   rnd;
    logic [31:0]   shape;
    addr_t         cand;
    addr_t         ramp;
    logic [TW-1:0] stall_cnt;
    logic          accept;

    assign accept = valid & ready;
    assign valid  = shape[0] & en & ~slot_busy & ~hold;

    lfsr32 i_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .advance (accept),
        .value   (rnd)
    );

    // Aligned random address, the ramp takes over outside the window
    assign cand      = {rnd[`MST_ADDR_W-1:2], 2'b00};
    assign req.addr  = (cand >= addr_min && cand <= addr_max) ? cand : ramp;
    assign req.id    = id_t'(`MST_ID_BASE) + id_t'(slot);
    assign stall_err = (stall_cnt == TMO);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            shape     <= '0;
            ramp      <= '0;
            slot      <= '0;
            stall_cnt <= '0;
        end else begin
            // Gap shaping, reloaded when drained or after a transfer
            if (en) begin
                if (shape == '0) begin
                    shape <= rnd;
                end else if (!valid) begin
                    shape <= shape >> 1;
                end else if (ready) begin
                    shape <= rnd;
                end
            end
            if (accept) begin
                ramp <= (ramp >= addr_max - addr_t'(16)) ? '0 : ramp + addr_t'(4);
                slot <= (slot == SW'(`MST_OSTD - 1)) ? '0 : slot + 1'b1;
            end
            if (valid && !ready) begin
                if (stall_cnt != TMO) begin
                    stall_cnt <= stall_cnt + 1'b1;
                end
            end else begin
                stall_cnt <= '0;
            end
        end
    end

    a_req_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (valid && !ready) ##1 en |-> valid && $stable(req));

endmodule

`default_nettype wire

// File: design/lfsr32.sv
// 32-bit Galois LFSR
`default_nettype none
`include "mst_macros.svh"

module lfsr32 (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        advance,
    output logic [31:0] value
);

    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] TAPS = 32'h8020_0003;

    logic [31:0] feedback;

    assign feedback = value[0] ? TAPS : 32'h0;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            value <= `MST_LFSR_KEY;
        end else if (advance) begin
            value <= {1'b0, value[31:1]} ^ feedback;
        end
    end

endmodule

`default_nettype wire

// File: design/mst_driver.sv
// AXI4-lite traffic master
`default_nettype none
`include "mst_macros.svh"

module mst_driver
    import mst_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      en,
    input  addr_t     addr_min,
    input  addr_t     addr_max,
    output logic      error,
    output addr_req_t aw,
    output logic      aw_valid,
    input  logic      aw_ready,
    output data_t     w_data,
    output logic      w_valid,
    input  logic      w_ready,
    input  rsp_t      b,
    input  logic      b_valid,
    output logic      b_ready,
    output addr_req_t ar,
    output logic      ar_valid,
    input  logic      ar_ready,
    input  rsp_t      r,
    input  logic      r_valid,
    output logic      r_ready
);

    logic [$clog2(`MST_OSTD)-1:0] aw_slot;
    logic [$clog2(`MST_OSTD)-1:0] ar_slot;
    logic aw_busy;
    logic ar_busy;
    logic q_full;
    logic aw_stall;
    logic w_stall;
    logic ar_stall;
    logic wr_err;
    logic rd_err;

    ////////////////////////////////////////
    // Write path
    ////////////////////////////////////////

    addr_gen i_aw_gen (
        .aclk (aclk), .aresetn (aresetn), .en (en),
        .addr_min (addr_min), .addr_max (addr_max),
        .slot_busy (aw_busy), .hold (q_full),
        .valid (aw_valid), .ready (aw_ready), .req (aw),
        .slot (aw_slot), .stall_err (aw_stall)
    );

    wdata_queue i_wq (
        .aclk (aclk), .aresetn (aresetn), .en (en),
        .push (aw_valid & aw_ready), .push_addr (aw.addr), .full (q_full),
        .valid (w_valid), .ready (w_ready), .data (w_data),
        .stall_err (w_stall)
    );

    or_tracker #(.KIND (TXN_WRITE)) i_wr_trk (
        .aclk (aclk), .aresetn (aresetn), .en (en),
        .req_accept (aw_valid & aw_ready), .req (aw), .req_slot (aw_slot),
        .slot_busy (aw_busy), .rsp_valid (b_valid), .rsp_ready (b_ready),
        .rsp (b), .error (wr_err)
    );

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    // Reads never wait on write data
    addr_gen i_ar_gen (
        .aclk (aclk), .aresetn (aresetn), .en (en),
        .addr_min (addr_min), .addr_max (addr_max),
        .slot_busy (ar_busy), .hold (1'b0),
        .valid (ar_valid), .ready (ar_ready), .req (ar),
        .slot (ar_slot), .stall_err (ar_stall)
    );

    or_tracker #(.KIND (TXN_READ)) i_rd_trk (
        .aclk (aclk), .aresetn (aresetn), .en (en),
        .req_accept (ar_valid & ar_ready), .req (ar), .req_slot (ar_slot),
        .slot_busy (ar_busy), .rsp_valid (r_valid), .rsp_ready (r_ready),
        .rsp (r), .error (rd_err)
    );

    assign error = en & (aw_stall | w_stall | ar_stall | wr_err | rd_err);

endmodule

`default_nettype wire

// File: design/mst_macros.svh
// Traffic master parameters
`ifndef MST_MACROS_SVH
`define MST_MACROS_SVH

// Bus widths
`define MST_ADDR_W    16
`define MST_DATA_W    32
`define MST_ID_W      8

// ID range and outstanding slots per direction
`define MST_ID_BASE   'h10
`define MST_OSTD      4

// Cycle limit shared by channel stalls and slot lifetimes
`define MST_TIMEOUT   100
`define MST_WQ_DEPTH  8

// Addresses outside this window expect DECERR
`define MST_SLV_START 16'h0000
`define MST_SLV_END   16'h0FFF

`define MST_LFSR_KEY  32'hC0DE_5EED
`define MST_DATA_SALT 32'h5A5A_A5A5

`endif

// File: design/mst_pkg.sv
// Traffic master types
`default_nettype none
`include "mst_macros.svh"

package mst_pkg;

    typedef logic [`MST_ADDR_W-1:0] addr_t;
    typedef logic [`MST_DATA_W-1:0] data_t;
    typedef logic [`MST_ID_W-1:0]   id_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // Direction served by a tracker
    typedef enum logic {
        TXN_WRITE,
        TXN_READ
    } txn_kind_e;

    // AW and AR payload
    typedef struct packed {
        addr_t addr;
        id_t   id;
    } addr_req_t;

    // B and R payload, data is zero on B
    typedef struct packed {
        id_t       id;
        axi_resp_e resp;
        data_t     data;
    } rsp_t;

    // Address copied into both halves of the word, then salted
    function automatic data_t data_of(input addr_t addr);
        return data_t'({addr, addr}) ^ data_t'(`MST_DATA_SALT);
    endfunction

    // Offset compare covers the whole window in one test
    function automatic axi_resp_e resp_of(input addr_t addr);
        addr_t offset;
        offset = addr - addr_t'(`MST_SLV_START);
        return (offset <= addr_t'(`MST_SLV_END - `MST_SLV_START)) ? OKAY : DECERR;
    endfunction

endpackage

`default_nettype wire

// File: design/or_tracker.sv
// Outstanding request tracker
`default_nettype none
`include "mst_macros.svh"

module or_tracker
    import mst_pkg::*;
#(
    parameter txn_kind_e KIND = TXN_WRITE
) (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         en,
    input  logic                         req_accept,
    input  addr_req_t                    req,
    input  logic [$clog2(`MST_OSTD)-1:0] req_slot,
    output logic                         slot_busy,
    input  logic                         rsp_valid,
    output logic                         rsp_ready,
    input  rsp_t                         rsp,
    output logic                         error
);

    localparam int TW = $clog2(`MST_TIMEOUT + 1);
    localparam logic [TW-1:0] TMO = TW'(`MST_TIMEOUT);

    logic [`MST_OSTD-1:0] busy;
    rsp_t                 exp_q [`MST_OSTD];
    logic [TW-1:0]        age [`MST_OSTD];
    logic [`MST_OSTD-1:0] hit;
    logic [`MST_OSTD-1:0] tmo;
    logic                 bad;
    logic                 chk_err;
    logic [31:0]          rnd;
    logic [31:0]          shape;
    logic                 rsp_hs;

    assign rsp_hs    = rsp_valid & rsp_ready;
    assign rsp_ready = shape[0];
    assign slot_busy = busy[req_slot];
    assign error     = chk_err | (|tmo);

    lfsr32 i_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .advance (rsp_hs),
        .value   (rnd)
    );

    ////////////////////////////////////////
    // Response matching
    ////////////////////////////////////////

    always_comb begin
        hit = '0;
        bad = 1'b0;
        for (int i = 0; i < `MST_OSTD; i++) begin
            tmo[i] = busy[i] && (age[i] == TMO);
            if (rsp_hs && busy[i] && exp_q[i].id == rsp.id) begin
                hit[i] = 1'b1;
                // Write responses carry no data worth checking
                if (exp_q[i].resp != rsp.resp ||
                    (KIND == TXN_READ && exp_q[i].data != rsp.data)) begin
                    bad = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (req_accept) begin
            exp_q[req_slot] <= '{id: req.id, resp: resp_of(req.addr), data: data_of(req.addr)};
        end
    end

    ////////////////////////////////////////
    // Slot state and timeouts
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy    <= '0;
            chk_err <= 1'b0;
            for (int i = 0; i < `MST_OSTD; i++) begin
                age[i] <= '0;
            end
        end else begin
            chk_err <= bad;
            for (int i = 0; i < `MST_OSTD; i++) begin
                if (req_accept && int'(req_slot) == i) begin
                    busy[i] <= 1'b1;
                end else if (hit[i]) begin
                    busy[i] <= 1'b0;
                end
                // Lifetime only advances while the master is enabled
                if (!busy[i]) begin
                    age[i] <= '0;
                end else if (en && age[i] != TMO) begin
                    age[i] <= age[i] + 1'b1;
                end
            end
        end
    end

    // Ready shaping keeps draining responses even with en low
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            shape <= '0;
        end else if (shape == '0) begin
            shape <= rnd;
        end else if (!rsp_ready) begin
            shape <= shape >> 1;
        end else if (rsp_valid) begin
            shape <= rnd;
        end
    end

    a_no_reload: assert property (@(posedge aclk) disable iff (!aresetn)
        req_accept |-> !busy[req_slot]);

endmodule

`default_nettype wire

// File: design/wdata_queue.sv
// Write data queue and W channel
`default_nettype none
`include "mst_macros.svh"

module wdata_queue
    import mst_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  en,
    input  logic  push,
    input  addr_t push_addr,
    output logic  full,
    output logic  valid,
    input  logic  ready,
    output data_t data,
    output logic  stall_err
);

    localparam int DEPTH = `MST_WQ_DEPTH;
    localparam int PW = $clog2(DEPTH);
    localparam int TW = $clog2(`MST_TIMEOUT + 1);
    localparam logic [TW-1:0] TMO = TW'(`MST_TIMEOUT);

    data_t         mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;
    logic [31:0]   rnd;
    logic [31:0]   shape;
    logic [TW-1:0] stall_cnt;
    logic          pop;

    assign pop       = valid & ready;
    assign full      = (count == (PW + 1)'(DEPTH));
    assign valid     = shape[0] & en & (count != '0);
    assign data      = mem[rd_ptr];
    assign stall_err = (stall_cnt == TMO);

    lfsr32 i_lfsr (
        .aclk    (aclk),
        .aresetn (aresetn),
        .advance (pop),
        .value   (rnd)
    );

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= data_of(push_addr);
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            shape     <= '0;
            stall_cnt <= '0;
        end else begin
            wr_ptr <= wr_ptr + PW'(push);
            rd_ptr <= rd_ptr + PW'(pop);
            count  <= count + (PW + 1)'(push) - (PW + 1)'(pop);
            if (en) begin
                if (shape == '0) begin
                    shape <= rnd;
                end else if (!valid) begin
                    shape <= shape >> 1;
                end else if (ready) begin
                    shape <= rnd;
                end
            end
            if (valid && !ready) begin
                if (stall_cnt != TMO) begin
                    stall_cnt <= stall_cnt + 1'b1;
                end
            end else begin
                stall_cnt <= '0;
            end
        end
    end

    // AW generator must hold off while the queue is full
    a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
        push |-> !full);

endmodule

`default_nettype wire

// File: files.f
+incdir+design
design/mst_pkg.sv
design/lfsr32.sv
design/addr_gen.sv
design/wdata_queue.sv
design/or_tracker.sv
design/mst_driver.sv
verif/axi_lite_slave_model.sv
verif/tb_mst_driver.sv

// File: run.sh
#!/bin/sh
# Build and run the traffic master testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_mst_driver -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mst_driver)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

// File: verif/axi_lite_slave_model.sv
// AXI4-lite slave model
`default_nettype none
`include "mst_macros.svh"

module axi_lite_slave_model
    import mst_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      corrupt_r,
    input  logic      flip_b,
    input  logic      mute_b,
    input  addr_req_t aw,
    input  logic      aw_valid,
    output logic      aw_ready,
    input  logic      w_valid,
    output logic      w_ready,
    output rsp_t      b,
    output logic      b_valid,
    input  logic      b_ready,
    input  addr_req_t ar,
    input  logic      ar_valid,
    output logic      ar_ready,
    output rsp_t      r,
    output logic      r_valid,
    input  logic      r_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    addr_req_t aw_q [$];
    addr_req_t b_pend [$];
    addr_req_t r_pend [$];
    int        w_cnt;

    // Oldest entry half the time, otherwise any entry
    function automatic int pick(input int n);
        return ($urandom % 2) ? 0 : int'($urandom % n);
    endfunction

    always @(posedge aclk or negedge aresetn) begin
        int        idx;
        addr_req_t e;
        if (!aresetn) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            ar_ready <= 1'b0;
            b_valid  <= 1'b0;
            r_valid  <= 1'b0;
            b        <= '0;
            r        <= '0;
            aw_q.delete();
            b_pend.delete();
            r_pend.delete();
            w_cnt = 0;
        end else begin
            if (aw_valid && aw_ready) aw_q.push_back(aw);
            if (w_valid && w_ready) w_cnt++;
            if (ar_valid && ar_ready) r_pend.push_back(ar);
            // A write is answerable once both its address and data arrived
            while (aw_q.size() > 0 && w_cnt > 0) begin
                b_pend.push_back(aw_q.pop_front());
                w_cnt--;
            end
            aw_ready <= ($urandom % 4) != 0;
            w_ready  <= ($urandom % 4) != 0;
            ar_ready <= ($urandom % 4) != 0;

            ////////////////////////////////////////
            // Responses, held until accepted
            ////////////////////////////////////////
            if (!b_valid || b_ready) begin
                b_valid <= 1'b0;
                if (b_pend.size() > 0 && !mute_b && ($urandom % 2)) begin
                    idx = pick(b_pend.size());
                    e   = b_pend[idx];
                    b_pend.delete(idx);
                    b_valid <= 1'b1;
                    b <= '{id: e.id, data: '0,
                           resp: flip_b ? axi_resp_e'(resp_of(e.addr) ^ 2'b11)
                                        : resp_of(e.addr)};
                end
            end
            if (!r_valid || r_ready) begin
                r_valid <= 1'b0;
                if (r_pend.size() > 0 && ($urandom % 2)) begin
                    idx = pick(r_pend.size());
                    e   = r_pend[idx];
                    r_pend.delete(idx);
                    r_valid <= 1'b1;
                    r <= '{id: e.id, resp: resp_of(e.addr),
                           data: corrupt_r ? data_of(e.addr) ^ 32'h1 : data_of(e.addr)};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_mst_driver.sv
// Traffic master testbench
`default_nettype none
`include "mst_macros.svh"

module tb_mst_driver
    import mst_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // Phases add up to about 4500 cycles
    localparam int LIMIT = 6000;

    logic      aclk;
    logic      aresetn;
    logic      en;
    addr_t     addr_min;
    addr_t     addr_max;
    logic      error;
    addr_req_t aw;
    logic      aw_valid;
    logic      aw_ready;
    data_t     w_data;
    logic      w_valid;
    logic      w_ready;
    rsp_t      b;
    logic      b_valid;
    logic      b_ready;
    addr_req_t ar;
    logic      ar_valid;
    logic      ar_ready;
    rsp_t      r;
    logic      r_valid;
    logic      r_ready;
    logic      corrupt_r;
    logic      flip_b;
    logic      mute_b;

    // Reference model state
    addr_t     aw_ramp;
    addr_t     ar_ramp;
    int        aw_slot;
    int        ar_slot;
    addr_t     wq [$];
    addr_req_t wr_os [$];
    addr_req_t rd_os [$];
    int        wr_cyc [$];
    int        cyc;
    int        err_cnt;
    int        hs_cnt;
    int        hs_mark;
    logic      exp_err;
    logic      clean;
    logic      mute_chk;
    logic      mute_seen;

    mst_driver i_dut (.*);

    axi_lite_slave_model i_slave (.*);

    always #50 aclk = ~aclk;

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_req(input string name, input addr_req_t exp, input addr_req_t act);
        if (exp !== act) begin
            err_cnt++;
            $display("[ERROR] %s expected addr %h id %h actual addr %h id %h",
                     name, exp.addr, exp.id, act.addr, act.id);
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            err_cnt++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_error(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            err_cnt++;
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
        end
    endtask

    function automatic int find_id(input bit rd, input id_t id);
        for (int i = 0; i < (rd ? rd_os.size() : wr_os.size()); i++) begin
            if ((rd ? rd_os[i].id : wr_os[i].id) == id) return i;
        end
        return -1;
    endfunction

    task automatic accept_req(input bit rd, input addr_req_t act);
        addr_req_t exp;
        addr_t     ramp;
        int        slot;
        int        n;
        ramp = rd ? ar_ramp : aw_ramp;
        slot = rd ? ar_slot : aw_slot;
        n    = rd ? rd_os.size() : wr_os.size();
        // In the window only alignment is fixed, outside it the ramp
        exp.addr = (act.addr >= addr_min && act.addr <= addr_max) ?
                   {act.addr[`MST_ADDR_W-1:2], 2'b00} : ramp;
        exp.id   = id_t'(`MST_ID_BASE + slot);
        check_req(rd ? "ar_request" : "aw_request", exp, act);
        if (n >= `MST_OSTD || find_id(rd, act.id) >= 0) begin
            err_cnt++;
            $display("Too many requests outstanding or ID %h issued twice", act.id);
        end
        ramp = (ramp >= addr_max - addr_t'(16)) ? '0 : ramp + addr_t'(4);
        slot = (slot + 1) % `MST_OSTD;
        hs_cnt++;
        if (rd) begin
            ar_ramp = ramp;
            ar_slot = slot;
            rd_os.push_back(act);
        end else begin
            aw_ramp = ramp;
            aw_slot = slot;
            wr_os.push_back(act);
            wr_cyc.push_back(cyc);
            wq.push_back(act.addr);
        end
    endtask

    task automatic retire_rsp(input bit rd, input rsp_t rsp);
        int    i;
        addr_t a;
        i = find_id(rd, rsp.id);
        if (i < 0) begin
            err_cnt++;
            $display("Response ID %h matches no outstanding request", rsp.id);
            return;
        end
        a = rd ? rd_os[i].addr : wr_os[i].addr;
        if (rsp.resp !== resp_of(a) || (rd && rsp.data !== data_of(a))) exp_err = 1'b1;
        if (rd) begin
            rd_os.delete(i);
        end else begin
            wr_os.delete(i);
            wr_cyc.delete(i);
        end
    endtask

    ////////////////////////////////////////
    // Monitor and reference model
    ////////////////////////////////////////

    always @(posedge aclk) begin
        if (aresetn) begin
            cyc++;
            if (exp_err) check_error("error_after_bad_rsp", 1'b1, error);
            else if (clean) check_error("error_clean", 1'b0, error);
            exp_err = 1'b0;
            if (b_valid && b_ready) retire_rsp(1'b0, b);
            if (r_valid && r_ready) retire_rsp(1'b1, r);
            if (w_valid && w_ready) begin
                if (wq.size() == 0) begin
                    err_cnt++;
                    $display("W beat sent with no pending AW address");
                end else begin
                    check_data("w_data", data_of(wq.pop_front()), w_data);
                end
            end
            if (aw_valid && aw_ready) accept_req(1'b0, aw);
            if (ar_valid && ar_ready) accept_req(1'b1, ar);
            if (mute_chk && error && !mute_seen) begin
                mute_seen = 1'b1;
                if (wr_cyc.size() == 0 || cyc - wr_cyc[0] > `MST_TIMEOUT + 2) begin
                    err_cnt++;
                    $display("Slot timeout raised late or with no write outstanding");
                end
            end
        end
    end

    always @(posedge aclk) begin
        if (cyc >= LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cyc);
            $display("Test failed");
            $finish;
        end
    end

    // New window only while both address channels are idle
    task automatic run_window(input int n);
        addr_t lo;
        lo = addr_t'($urandom % 'h3000) & ~addr_t'(3);
        @(posedge aclk);
        while (aw_valid || ar_valid) @(posedge aclk);
        addr_min <= lo;
        addr_max <= lo + addr_t'('h40 + $urandom % 'h1000);
        repeat (n) @(posedge aclk);
    endtask

    initial begin
        void'($urandom(16));
        aclk      = 1'b0;
        aresetn   = 1'b0;
        en        = 1'b0;
        addr_min  = '0;
        addr_max  = 16'h0FFF;
        corrupt_r = 1'b0;
        flip_b    = 1'b0;
        mute_b    = 1'b0;
        clean     = 1'b0;
        mute_chk  = 1'b0;
        mute_seen = 1'b0;
        exp_err   = 1'b0;
        err_cnt   = 0;
        cyc       = 0;
        hs_cnt    = 0;
        aw_ramp   = '0;
        ar_ramp   = '0;
        aw_slot   = 0;
        ar_slot   = 0;
        repeat (8) @(posedge aclk);
        // Valids, readies and the error flag all sit low in reset
        check_error("reset_aw_valid", 1'b0, aw_valid);
        check_error("reset_w_valid", 1'b0, w_valid);
        check_error("reset_ar_valid", 1'b0, ar_valid);
        check_error("reset_b_ready", 1'b0, b_ready);
        check_error("reset_r_ready", 1'b0, r_ready);
        check_error("reset_error", 1'b0, error);
        aresetn <= 1'b1;
        @(posedge aclk);
        en    <= 1'b1;
        clean <= 1'b1;
        repeat (8) run_window(250);

        // Fault injection
        clean     <= 1'b0;
        corrupt_r <= 1'b1;
        repeat (300) @(posedge aclk);
        corrupt_r <= 1'b0;
        flip_b    <= 1'b1;
        repeat (300) @(posedge aclk);
        flip_b <= 1'b0;
        repeat (20) @(posedge aclk);
        mute_b   <= 1'b1;
        mute_chk <= 1'b1;
        for (int i = 0; i < 4 * `MST_TIMEOUT && !mute_seen; i++) @(posedge aclk);
        @(posedge aclk);
        if (!mute_seen) begin
            err_cnt++;
            $display("No error raised while B responses were muted");
        end
        mute_b   <= 1'b0;
        mute_chk <= 1'b0;
        repeat (300) @(posedge aclk);

        // Master disabled, then resumed
        clean <= 1'b1;
        en    <= 1'b0;
        @(posedge aclk);
        repeat (200) begin
            @(posedge aclk);
            check_error("en_low_aw_valid", 1'b0, aw_valid);
            check_error("en_low_w_valid", 1'b0, w_valid);
            check_error("en_low_ar_valid", 1'b0, ar_valid);
            check_error("en_low_error", 1'b0, error);
        end
        hs_mark = hs_cnt;
        en <= 1'b1;
        repeat (4) run_window(250);
        if (hs_cnt - hs_mark < 10) begin
            err_cnt++;
            $display("Traffic did not resume after en rose again");
        end

        $display("Checks finished with %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
